// ==== design/chipset_pkg.sv ====
// PC/XT chipset shared definitions
package chipset_pkg;

    // Bus widths
    localparam int ADDRESS_WIDTH = 20;
    localparam int DATA_WIDTH    = 8;
    localparam int STATUS_WIDTH  = 3;
    localparam int WAIT_WIDTH    = 2;

    // Fixed waits for I/O cycles
    localparam logic [WAIT_WIDTH-1:0] IO_WAIT_CYCLES = WAIT_WIDTH'(1);

    // DMA channel 0 refresh interval in clocks
    localparam int REFRESH_PERIOD      = 18;
    localparam int REFRESH_COUNT_WIDTH = $clog2(REFRESH_PERIOD);
    localparam logic [REFRESH_COUNT_WIDTH-1:0] REFRESH_TERMINAL =
        REFRESH_COUNT_WIDTH'(REFRESH_PERIOD - 1);

    // 640 KB of RAM below this address
    localparam logic [ADDRESS_WIDTH-1:0] RAM_TOP    = 20'hA0000;
    localparam logic [15:0]              XTCTL_PORT = 16'h8888;

    // 8088 S2..S0 encodings
    typedef enum logic [STATUS_WIDTH-1:0] {
        int_ack    = 3'd0,
        io_read    = 3'd1,
        io_write   = 3'd2,
        halt       = 3'd3,
        code_fetch = 3'd4,
        mem_read   = 3'd5,
        mem_write  = 3'd6,
        passive    = 3'd7
    } bus_command_e;

    typedef enum logic [2:0] {
        idle = 3'd0,
        t1   = 3'd1,
        t2   = 3'd2,
        t3   = 3'd3,
        t4   = 3'd4
    } bus_state_e;

endpackage

// ==== design/address_latch.sv ====
// Address latch and RAM decode
`timescale 1ns/1ps

module address_latch (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic                                  address_latch_enable,
    input  logic [chipset_pkg::ADDRESS_WIDTH-1:0] cpu_address,
    output logic [chipset_pkg::ADDRESS_WIDTH-1:0] address,
    output logic                                  ram_select_n
);

    // Captured at the end of T1
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            address <= '0;
        else if (address_latch_enable)
            address <= cpu_address;
    end

    // Conventional memory region
    assign ram_select_n = (address >= chipset_pkg::RAM_TOP);

endmodule

// ==== design/bus_cycle_fsm.sv ====
// 8088 bus cycle state machine
`timescale 1ns/1ps

module bus_cycle_fsm (
    input  logic                                 clock,
    input  logic                                 reset,
    input  logic [chipset_pkg::STATUS_WIDTH-1:0] processor_status,
    input  logic                                 wait_done,
    output logic                                 address_latch_enable,
    output logic                                 wait_load,
    output chipset_pkg::bus_command_e            bus_command,
    output logic                                 io_read_n,
    output logic                                 io_write_n,
    output logic                                 memory_read_n,
    output logic                                 memory_write_n,
    output logic                                 interrupt_acknowledge_n,
    output logic                                 processor_ready
);

    chipset_pkg::bus_state_e   state;
    chipset_pkg::bus_state_e   next_state;
    chipset_pkg::bus_command_e status_command;
    chipset_pkg::bus_command_e decoded_command;
    logic                      cycle_start;
    logic                      strobe_active;

    assign status_command = chipset_pkg::bus_command_e'(processor_status);

    // Halt runs no cycle
    assign cycle_start = (status_command != chipset_pkg::passive)
                      && (status_command != chipset_pkg::halt);

    // Code fetch is an ordinary memory read on the bus
    assign decoded_command = (status_command == chipset_pkg::code_fetch)
                           ? chipset_pkg::mem_read : status_command;

    always_comb
    begin
        next_state = state;
        case (state)
            chipset_pkg::idle:
                if (cycle_start)
                    next_state = chipset_pkg::t1;
            chipset_pkg::t1:
                next_state = chipset_pkg::t2;
            chipset_pkg::t2:
                next_state = wait_done ? chipset_pkg::t4 : chipset_pkg::t3;
            chipset_pkg::t3:
                if (wait_done)
                    next_state = chipset_pkg::t4;
            chipset_pkg::t4:
                next_state = chipset_pkg::idle;
            default:
                next_state = chipset_pkg::idle;
        endcase
    end

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
        begin
            state       <= chipset_pkg::idle;
            bus_command <= chipset_pkg::passive;
        end
        else
        begin
            state <= next_state;
            if ((state == chipset_pkg::idle) && cycle_start)
                bus_command <= decoded_command;
        end
    end

    assign strobe_active        = (state == chipset_pkg::t2) || (state == chipset_pkg::t3);
    assign address_latch_enable = (state == chipset_pkg::t1);
    assign wait_load            = (state == chipset_pkg::t2);

    // Command strobes low through T2 and T3
    assign io_read_n      = ~(strobe_active && (bus_command == chipset_pkg::io_read));
    assign io_write_n     = ~(strobe_active && (bus_command == chipset_pkg::io_write));
    assign memory_read_n  = ~(strobe_active && (bus_command == chipset_pkg::mem_read));
    assign memory_write_n = ~(strobe_active && (bus_command == chipset_pkg::mem_write));
    assign interrupt_acknowledge_n =
        ~(strobe_active && (bus_command == chipset_pkg::int_ack));

    // Ready drops until the waits run out
    assign processor_ready = ~(strobe_active && ~wait_done);

endmodule

// ==== design/wait_state_counter.sv ====
// Bus cycle wait-state counter
`timescale 1ns/1ps

module wait_state_counter (
    input  logic                               clock,
    input  logic                               reset,
    input  logic                               wait_load,
    input  chipset_pkg::bus_command_e          bus_command,
    input  logic                               ram_select_n,
    input  logic [chipset_pkg::WAIT_WIDTH-1:0] ram_read_wait_cycle,
    input  logic [chipset_pkg::WAIT_WIDTH-1:0] ram_write_wait_cycle,
    input  logic                               io_channel_ready,
    output logic                               wait_done
);

    logic [chipset_pkg::WAIT_WIDTH-1:0] wait_cycles;
    logic [chipset_pkg::WAIT_WIDTH-1:0] load_count;
    logic [chipset_pkg::WAIT_WIDTH-1:0] count;

    always_comb
    begin
        case (bus_command)
            chipset_pkg::mem_read:
                wait_cycles = ram_select_n ? '0 : ram_read_wait_cycle;
            chipset_pkg::mem_write:
                wait_cycles = ram_select_n ? '0 : ram_write_wait_cycle;
            chipset_pkg::io_read,
            chipset_pkg::io_write:
                wait_cycles = chipset_pkg::IO_WAIT_CYCLES;
            default:
                wait_cycles = '0;
        endcase
    end

    // T2 itself covers the first wait
    assign load_count = (wait_cycles == '0) ? '0 : wait_cycles - chipset_pkg::WAIT_WIDTH'(1);

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            count <= '0;
        else if (wait_load)
            count <= load_count;
        // Holds while the channel is not ready
        else if (io_channel_ready && (count != '0))
            count <= count - chipset_pkg::WAIT_WIDTH'(1);
    end

    assign wait_done = io_channel_ready && (wait_load ? (wait_cycles == '0) : (count == '0));

endmodule

// ==== design/refresh_timer.sv ====
// DMA refresh request timer
`timescale 1ns/1ps

module refresh_timer (
    input  logic clock,
    input  logic reset,
    input  logic dma_acknowledge_0_n,
    output logic refresh_request
);

    logic [chipset_pkg::REFRESH_COUNT_WIDTH-1:0] refresh_count;
    logic                                        terminal_count;

    assign terminal_count = (refresh_count == chipset_pkg::REFRESH_TERMINAL);

    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            refresh_count <= '0;
        else if (terminal_count)
            refresh_count <= '0;
        else
            refresh_count <= refresh_count + 1'b1;
    end

    // Acknowledge wins over a new request
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            refresh_request <= 1'b0;
        else if (~dma_acknowledge_0_n)
            refresh_request <= 1'b0;
        else if (terminal_count)
            refresh_request <= 1'b1;
    end

endmodule

// ==== design/chipset_data_path.sv ====
// Chipset read data steering and xtctl
`timescale 1ns/1ps

module chipset_data_path (
    input  logic                                  clock,
    input  logic                                  reset,
    input  logic [chipset_pkg::ADDRESS_WIDTH-1:0] address,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    cpu_write_data,
    input  logic                                  io_read_n,
    input  logic                                  io_write_n,
    input  logic                                  memory_read_n,
    input  logic                                  interrupt_acknowledge_n,
    input  logic                                  ram_select_n,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    ram_data_in,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    data_bus_ext,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    cpu_read_data,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    data_bus,
    output logic                                  data_bus_direction,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    xtctl
);

    logic xtctl_selected;

    // I/O space decodes 16 bits only
    assign xtctl_selected = (address[15:0] == chipset_pkg::XTCTL_PORT);

    // Last strobe clock leaves the final value
    always_ff @(posedge clock, posedge reset)
    begin
        if (reset)
            xtctl <= '0;
        else if (~io_write_n && xtctl_selected)
            xtctl <= cpu_write_data;
    end

    always_comb
    begin
        cpu_read_data      = '0;
        data_bus_direction = 1'b0;
        if (~io_read_n && xtctl_selected)
            cpu_read_data = xtctl;
        else if (~memory_read_n && ~ram_select_n)
            cpu_read_data = ram_data_in;
        else if (~io_read_n || ~memory_read_n || ~interrupt_acknowledge_n)
        begin
            // Read from a card on the bus
            cpu_read_data      = data_bus_ext;
            data_bus_direction = 1'b1;
        end
    end

    assign data_bus = cpu_write_data;

endmodule

// ==== design/pc_xt_chipset.sv ====
// PC/XT bus controller top level
`timescale 1ns/1ps

module pc_xt_chipset (
    input  logic                                  clock,
    input  logic                                  reset,
    // CPU side
    input  logic [chipset_pkg::ADDRESS_WIDTH-1:0] cpu_address,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    cpu_write_data,
    input  logic [chipset_pkg::STATUS_WIDTH-1:0]  processor_status,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    cpu_read_data,
    output logic                                  processor_ready,
    // Expansion bus
    output logic [chipset_pkg::ADDRESS_WIDTH-1:0] address,
    output logic                                  address_latch_enable,
    output logic                                  io_read_n,
    output logic                                  io_write_n,
    output logic                                  memory_read_n,
    output logic                                  memory_write_n,
    output logic                                  interrupt_acknowledge_n,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    data_bus,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    data_bus_ext,
    output logic                                  data_bus_direction,
    input  logic                                  io_channel_ready,
    // RAM
    output logic                                  ram_select_n,
    input  logic [chipset_pkg::DATA_WIDTH-1:0]    ram_data_in,
    input  logic [chipset_pkg::WAIT_WIDTH-1:0]    ram_read_wait_cycle,
    input  logic [chipset_pkg::WAIT_WIDTH-1:0]    ram_write_wait_cycle,
    // DMA refresh
    output logic                                  refresh_request,
    input  logic                                  dma_acknowledge_0_n,
    output logic [chipset_pkg::DATA_WIDTH-1:0]    xtctl
);

    logic                      wait_load;
    logic                      wait_done;
    chipset_pkg::bus_command_e bus_command;

    bus_cycle_fsm i_bus_cycle_fsm (
        .clock                   (clock),
        .reset                   (reset),
        .processor_status        (processor_status),
        .wait_done               (wait_done),
        .address_latch_enable    (address_latch_enable),
        .wait_load               (wait_load),
        .bus_command             (bus_command),
        .io_read_n               (io_read_n),
        .io_write_n              (io_write_n),
        .memory_read_n           (memory_read_n),
        .memory_write_n          (memory_write_n),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .processor_ready         (processor_ready)
    );

    wait_state_counter i_wait_state_counter (
        .clock                (clock),
        .reset                (reset),
        .wait_load            (wait_load),
        .bus_command          (bus_command),
        .ram_select_n         (ram_select_n),
        .ram_read_wait_cycle  (ram_read_wait_cycle),
        .ram_write_wait_cycle (ram_write_wait_cycle),
        .io_channel_ready     (io_channel_ready),
        .wait_done            (wait_done)
    );

    refresh_timer i_refresh_timer (
        .clock               (clock),
        .reset               (reset),
        .dma_acknowledge_0_n (dma_acknowledge_0_n),
        .refresh_request     (refresh_request)
    );

    address_latch i_address_latch (
        .clock                (clock),
        .reset                (reset),
        .address_latch_enable (address_latch_enable),
        .cpu_address          (cpu_address),
        .address              (address),
        .ram_select_n         (ram_select_n)
    );

    chipset_data_path i_chipset_data_path (
        .clock                   (clock),
        .reset                   (reset),
        .address                 (address),
        .cpu_write_data          (cpu_write_data),
        .io_read_n               (io_read_n),
        .io_write_n              (io_write_n),
        .memory_read_n           (memory_read_n),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .ram_select_n            (ram_select_n),
        .ram_data_in             (ram_data_in),
        .data_bus_ext            (data_bus_ext),
        .cpu_read_data           (cpu_read_data),
        .data_bus                (data_bus),
        .data_bus_direction      (data_bus_direction),
        .xtctl                   (xtctl)
    );

endmodule

// ==== verification/chipset_tb.sv ====
// Bus controller testbench
`timescale 1ns/1ps

module chipset_tb;

    localparam int    TRACE_LINES  = 16;
    localparam int    TRACE_FIELDS = 9;
    localparam string TRACE_FILE   = "verification/chipset_trace.txt";
    localparam int    RESET_CYCLES = 16;
    localparam int    DRIVE_DELAY  = 5;
    // Worst bus cycle is about 12 clocks with the longest wait and stall
    localparam int    TIMEOUT_CYCLES = RESET_CYCLES + 3 * chipset_pkg::REFRESH_PERIOD
                                     + TRACE_LINES * 12 + 64;

    logic        clock;
    logic        reset;
    logic [19:0] cpu_address;
    logic [7:0]  cpu_write_data;
    logic [2:0]  processor_status;
    logic [7:0]  data_bus_ext;
    logic [7:0]  ram_data_in;
    logic        io_channel_ready;
    logic [1:0]  ram_read_wait_cycle;
    logic [1:0]  ram_write_wait_cycle;
    logic        dma_acknowledge_0_n;
    logic [7:0]  cpu_read_data;
    logic        processor_ready;
    logic [19:0] address;
    logic        address_latch_enable;
    logic        io_read_n;
    logic        io_write_n;
    logic        memory_read_n;
    logic        memory_write_n;
    logic        interrupt_acknowledge_n;
    logic [7:0]  data_bus;
    logic        data_bus_direction;
    logic        ram_select_n;
    logic        refresh_request;
    logic [7:0]  xtctl;

    logic [19:0] trace_mem [0:TRACE_LINES*TRACE_FIELDS-1];
    logic [7:0]  lfsr_state;
    logic [7:0]  model_xtctl;
    int          mismatch_count;
    int          failure_count;
    int          cycle_count;
    int          rise_clock;
    int          since_rise;

    pc_xt_chipset i_dut (
        .clock(clock), .reset(reset), .cpu_address(cpu_address),
        .cpu_write_data(cpu_write_data), .processor_status(processor_status),
        .cpu_read_data(cpu_read_data), .processor_ready(processor_ready),
        .address(address), .address_latch_enable(address_latch_enable),
        .io_read_n(io_read_n), .io_write_n(io_write_n), .memory_read_n(memory_read_n),
        .memory_write_n(memory_write_n), .interrupt_acknowledge_n(interrupt_acknowledge_n),
        .data_bus(data_bus), .data_bus_ext(data_bus_ext),
        .data_bus_direction(data_bus_direction), .io_channel_ready(io_channel_ready),
        .ram_select_n(ram_select_n), .ram_data_in(ram_data_in),
        .ram_read_wait_cycle(ram_read_wait_cycle),
        .ram_write_wait_cycle(ram_write_wait_cycle),
        .refresh_request(refresh_request), .dma_acknowledge_0_n(dma_acknowledge_0_n),
        .xtctl(xtctl)
    );

    initial
    begin
        clock = 1'b0;
        forever #50 clock = ~clock;
    end

    always @(posedge clock)
    begin
        cycle_count = cycle_count + 1;
        if (cycle_count > TIMEOUT_CYCLES)
        begin
            $display("Timeout: no progress after %0d clocks", cycle_count);
            $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count + 1);
            $display("Errors found");
            $finish;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsr_step(input logic [7:0] value);
        lfsr_step = {value[6:0], value[7] ^ value[5] ^ value[4] ^ value[3]};
    endfunction

    task automatic next_stall(output int stall);
        stall = 0;
        repeat (2)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            stall = stall * 2 + int'(lfsr_state[0]);
        end
    endtask

    task automatic report_mismatch(input string message);
        $display("MISMATCH at %0d ns: %s", $time, message);
        mismatch_count = mismatch_count + 1;
    endtask

    // Order: ior, iow, memr, memw, inta
    function automatic logic [4:0] strobe_pattern(input logic [2:0] status);
        case (status)
            chipset_pkg::int_ack:    strobe_pattern = 5'b11110;
            chipset_pkg::io_read:    strobe_pattern = 5'b01111;
            chipset_pkg::io_write:   strobe_pattern = 5'b10111;
            chipset_pkg::code_fetch,
            chipset_pkg::mem_read:   strobe_pattern = 5'b11011;
            chipset_pkg::mem_write:  strobe_pattern = 5'b11101;
            default:                 strobe_pattern = 5'b11111;
        endcase
    endfunction

    function automatic int wait_count(input logic [2:0] status, input logic [19:0] addr,
                                      input logic [1:0] read_wait, input logic [1:0] write_wait);
        logic in_ram;
        in_ram = (addr < chipset_pkg::RAM_TOP);
        case (status)
            chipset_pkg::code_fetch,
            chipset_pkg::mem_read:  wait_count = in_ram ? int'(read_wait) : 0;
            chipset_pkg::mem_write: wait_count = in_ram ? int'(write_wait) : 0;
            chipset_pkg::io_read,
            chipset_pkg::io_write:  wait_count = int'(chipset_pkg::IO_WAIT_CYCLES);
            default:                wait_count = 0;
        endcase
    endfunction

    // Bus drives the CPU unless xtctl or RAM answers
    function automatic logic expected_direction(input logic [2:0] status,
                                                input logic [19:0] addr);
        logic mem_read_cycle;
        mem_read_cycle = (status == chipset_pkg::mem_read) || (status == chipset_pkg::code_fetch);
        if ((status == chipset_pkg::io_read) && (addr[15:0] == chipset_pkg::XTCTL_PORT))
            expected_direction = 1'b0;
        else if (mem_read_cycle && (addr < chipset_pkg::RAM_TOP))
            expected_direction = 1'b0;
        else
            expected_direction = mem_read_cycle || (status == chipset_pkg::io_read)
                              || (status == chipset_pkg::int_ack);
    endfunction

    task automatic run_bus_cycle(input int line);
        int          base;
        int          stall;
        int          stall_left;
        int          low_clocks;
        int          ale_clocks;
        int          waits;
        logic        done;
        logic [2:0]  status;
        logic [19:0] cycle_address;
        logic [4:0]  strobes;
        base          = line * TRACE_FIELDS;
        status        = trace_mem[base][2:0];
        cycle_address = trace_mem[base+1];
        waits = wait_count(status, cycle_address, trace_mem[base+5][1:0], trace_mem[base+6][1:0]);
        next_stall(stall);
        @(posedge clock);
        #DRIVE_DELAY;
        processor_status     = status;
        cpu_address          = cycle_address;
        cpu_write_data       = trace_mem[base+2][7:0];
        data_bus_ext         = trace_mem[base+3][7:0];
        ram_data_in          = trace_mem[base+4][7:0];
        ram_read_wait_cycle  = trace_mem[base+5][1:0];
        ram_write_wait_cycle = trace_mem[base+6][1:0];
        io_channel_ready     = (stall == 0);
        stall_left = stall;
        low_clocks = 0;
        ale_clocks = 0;
        done       = 1'b0;
        while (!done)
        begin
            @(negedge clock);
            strobes = {io_read_n, io_write_n, memory_read_n, memory_write_n,
                       interrupt_acknowledge_n};
            if (address_latch_enable)
                ale_clocks = ale_clocks + 1;
            if (strobes != 5'b11111)
            begin
                low_clocks = low_clocks + 1;
                if (strobes != strobe_pattern(status))
                    report_mismatch($sformatf("line %0d: strobes %b", line, strobes));
                if ((low_clocks == 1) && (ale_clocks != 1))
                    report_mismatch($sformatf("line %0d: ALE high %0d clocks", line, ale_clocks));
                if ((low_clocks == 1) && (address !== cycle_address))
                    report_mismatch($sformatf("line %0d: address %h", line, address));
                if ((low_clocks == 1) && (ram_select_n !== trace_mem[base+8][0]))
                    report_mismatch($sformatf("line %0d: ram_select_n %b", line, ram_select_n));
                if (processor_ready)
                begin
                    done = 1'b1;
                    if (cpu_read_data !== trace_mem[base+7][7:0])
                        report_mismatch($sformatf("line %0d: read data %h, expected %h",
                                                  line, cpu_read_data, trace_mem[base+7][7:0]));
                    if (data_bus_direction !== expected_direction(status, cycle_address))
                        report_mismatch($sformatf("line %0d: data_bus_direction %b",
                                                  line, data_bus_direction));
                    if (data_bus !== cpu_write_data)
                        report_mismatch($sformatf("line %0d: data_bus %h", line, data_bus));
                end
            end
            if (!done)
            begin
                @(posedge clock);
                #DRIVE_DELAY;
                if ((low_clocks > 0) && (stall_left > 0))
                    stall_left = stall_left - 1;
                io_channel_ready = (stall_left == 0);
            end
        end
        if ((stall == 0) && (low_clocks != waits + 1))
            report_mismatch($sformatf("line %0d: strobe low %0d clocks, expected %0d",
                                      line, low_clocks, waits + 1));
        // Channel is not ready in the first stall strobe clocks, so ready comes later
        if ((stall > 0) && ((low_clocks < waits + 1) || (low_clocks < stall + 1)
                            || (low_clocks > waits + 1 + stall)))
            report_mismatch($sformatf("line %0d: strobe low %0d clocks with stall %0d",
                                      line, low_clocks, stall));
        @(posedge clock);
        #DRIVE_DELAY;
        processor_status = chipset_pkg::passive;
        io_channel_ready = 1'b1;
        if ((status == chipset_pkg::io_write) && (cycle_address[15:0] == chipset_pkg::XTCTL_PORT))
            model_xtctl = trace_mem[base+2][7:0];
        // T4
        @(negedge clock);
        strobes = {io_read_n, io_write_n, memory_read_n, memory_write_n, interrupt_acknowledge_n};
        if ((strobes != 5'b11111) || !processor_ready)
            report_mismatch($sformatf("line %0d: cycle did not end in T4", line));
        if (xtctl !== model_xtctl)
            report_mismatch($sformatf("line %0d: xtctl %h, expected %h", line, xtctl, model_xtctl));
    endtask

    task automatic run_halt(input int line);
        @(posedge clock);
        #DRIVE_DELAY;
        processor_status = chipset_pkg::halt;
        repeat (4)
        begin
            @(negedge clock);
            if (address_latch_enable || !memory_read_n || !io_read_n || !processor_ready)
                report_mismatch($sformatf("line %0d: halt started a bus cycle", line));
        end
        @(posedge clock);
        #DRIVE_DELAY;
        processor_status = chipset_pkg::passive;
    endtask

    initial
    begin
        reset                = 1'b1;
        cpu_address          = '0;
        cpu_write_data       = '0;
        processor_status     = chipset_pkg::passive;
        data_bus_ext         = '0;
        ram_data_in          = '0;
        io_channel_ready     = 1'b1;
        ram_read_wait_cycle  = '0;
        ram_write_wait_cycle = '0;
        dma_acknowledge_0_n  = 1'b1;
        lfsr_state           = 8'd50;
        model_xtctl          = '0;
        mismatch_count       = 0;
        failure_count        = 0;
        cycle_count          = 0;
        // Entries the file does not reach keep an out-of-range value
        for (int i = 0; i < TRACE_LINES * TRACE_FIELDS; i++)
        begin
            trace_mem[i] = ~20'(i);
        end
        $readmemh(TRACE_FILE, trace_mem);
        repeat (RESET_CYCLES - 1) @(posedge clock);
        @(negedge clock);
        if (!io_read_n || !io_write_n || !memory_read_n || !memory_write_n
            || !interrupt_acknowledge_n || address_latch_enable || !processor_ready)
            report_mismatch("bus outputs not idle in reset");
        if ((refresh_request !== 1'b0) || (xtctl !== 8'h00))
            report_mismatch("refresh_request or xtctl not cleared by reset");
        @(posedge clock);
        #DRIVE_DELAY;
        reset = 1'b0;

        // First refresh request, counted from reset
        rise_clock = 0;
        for (int i = 1; (i <= 2 * chipset_pkg::REFRESH_PERIOD) && (rise_clock == 0); i++)
        begin
            @(posedge clock);
            @(negedge clock);
            if (refresh_request)
                rise_clock = i;
        end
        if (rise_clock != chipset_pkg::REFRESH_PERIOD)
            report_mismatch($sformatf("first refresh request after %0d clocks", rise_clock));
        repeat (4)
        begin
            @(posedge clock);
            @(negedge clock);
            if (!refresh_request)
                report_mismatch("refresh_request dropped without acknowledge");
        end
        @(posedge clock);
        #DRIVE_DELAY;
        dma_acknowledge_0_n = 1'b0;
        @(posedge clock);
        #DRIVE_DELAY;
        dma_acknowledge_0_n = 1'b1;
        @(negedge clock);
        if (refresh_request)
            report_mismatch("refresh_request still high after acknowledge");
        since_rise = 6;
        rise_clock = 0;
        while ((rise_clock == 0) && (since_rise < 2 * chipset_pkg::REFRESH_PERIOD))
        begin
            @(posedge clock);
            since_rise = since_rise + 1;
            @(negedge clock);
            if (refresh_request)
                rise_clock = since_rise;
        end
        if (rise_clock != chipset_pkg::REFRESH_PERIOD)
            report_mismatch($sformatf("refresh period %0d clocks", rise_clock));

        if ($isunknown(trace_mem[TRACE_LINES*TRACE_FIELDS-1])
            || (trace_mem[TRACE_LINES*TRACE_FIELDS-1] > 20'h1))
        begin
            $display("Trace file could not be read or is too short: %s", TRACE_FILE);
            failure_count = failure_count + 1;
        end
        else
        begin
            for (int line = 0; line < TRACE_LINES; line++)
            begin
                if (trace_mem[line*TRACE_FIELDS][2:0] == chipset_pkg::halt)
                    run_halt(line);
                else
                    run_bus_cycle(line);
            end
        end

        $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if ((mismatch_count == 0) && (failure_count == 0))
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

// ==== sources.f ====
design/chipset_pkg.sv
design/address_latch.sv
design/bus_cycle_fsm.sv
design/wait_state_counter.sv
design/refresh_timer.sv
design/chipset_data_path.sv
design/pc_xt_chipset.sv
verification/chipset_tb.sv

// ==== Makefile ====
VERILATOR    = verilator
FILE_LIST    = sources.f
TOP          = chipset_tb
RTL_TOP      = pc_xt_chipset
BUILD_DIR    = obj_dir
LINT_FLAGS   = --lint-only --timing
SIM_FLAGS    = --binary --timing --Mdir $(BUILD_DIR)
PASS_MESSAGE = No errors

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(RTL_TOP)
	$(VERILATOR) $(LINT_FLAGS) -f $(FILE_LIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILE_LIST) --top-module $(TOP)
	@output="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$output"; \
	echo "$$output" | grep -qx "$(PASS_MESSAGE)"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/chipset_trace.txt ====
// status address write_data ext_data ram_data read_wait write_wait
// expected_read_data expected_ram_select_n (all hex)
5 00400 00 3C A5 1 2 A5 0
6 01234 5A 77 11 1 2 00 0
4 9FFFF 00 C3 42 3 0 42 0
5 A0000 00 E7 99 3 3 E7 1
5 F0010 00 81 18 2 2 81 1
6 C8000 66 00 00 3 3 00 1
2 08888 3D 00 00 0 0 00 0
1 08888 00 FF 55 0 0 3D 0
1 00060 00 1C 66 0 0 1C 0
2 003F8 41 00 00 0 0 00 0
0 00000 00 08 BB 0 0 08 0
3 00000 00 00 00 0 0 00 0
2 08888 C6 00 00 0 0 00 0
5 08888 00 44 D2 2 1 D2 0
1 18888 00 2E 00 0 0 C6 0
6 9FFFF 7E 00 00 0 0 00 0
